// ==== Makefile ====
SIM       ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_decode_stage
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
+incdir+include
hdl/decode_pkg.sv
hdl/credit_fifo.sv
hdl/inst_decoder.sv
hdl/imm_gen.sv
hdl/decode_stall_fsm.sv
hdl/credit_counter.sv
hdl/decode_stage.sv
verification/decode_assert.sv
verification/decode_checker.sv
verification/tb_decode_stage.sv

// ==== hdl/credit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_counter #(
    parameter int OUT_CREDITS = 2
) (
    input  logic clk,
    input  logic arst_n,
    input  logic spend,
    input  logic credit_return,
    output logic has_credit
);

    localparam int CW = $clog2(OUT_CREDITS + 1);

    logic [CW-1:0] credits;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= CW'(OUT_CREDITS); // full window after reset
        end else begin
            case ({spend, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ; // spend and return cancel
            endcase
        end
    end

    assign has_credit = (credits != '0);

endmodule

`default_nettype wire

// ==== hdl/credit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
    parameter int  DEPTH = 4,
    parameter type T     = logic [31:0]
) (
    input  logic clk,
    input  logic arst_n,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     pop_data,
    output logic empty,
    output logic full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          wr_en;
    logic          rd_en;

    assign wr_en = push && !full; // push into a full queue is lost
    assign rd_en = pop && !empty;

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ; // both or neither
            endcase
        end
    end

    assign pop_data = mem[rd_ptr]; // head, valid while not empty
    assign empty    = (count == '0);
    assign full     = (count == CW'(DEPTH));

endmodule

`default_nettype wire

// ==== hdl/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [31:0] addr_t;

    typedef enum logic [6:0] {
        OPC7_R_TYPE = 7'b011_0011,
        OPC7_I_TYPE = 7'b001_0011,
        OPC7_LOAD   = 7'b000_0011,
        OPC7_STORE  = 7'b010_0011,
        OPC7_BRANCH = 7'b110_0011,
        OPC7_JALR   = 7'b110_0111,
        OPC7_JAL    = 7'b110_1111,
        OPC7_LUI    = 7'b011_0111,
        OPC7_AUIPC  = 7'b001_0111,
        OPC7_SYSTEM = 7'b111_0011
    } opc7_t;

    // {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_OP_ADD    = 4'b0000,
        ALU_OP_SLL    = 4'b0001,
        ALU_OP_SLT    = 4'b0010,
        ALU_OP_SLTU   = 4'b0011,
        ALU_OP_XOR    = 4'b0100,
        ALU_OP_SRL    = 4'b0101,
        ALU_OP_OR     = 4'b0110,
        ALU_OP_AND    = 4'b0111,
        ALU_OP_SUB    = 4'b1000,
        ALU_OP_SRA    = 4'b1101,
        ALU_OP_PASS_B = 4'b1111 // free slot, used by lui
    } alu_op_t;

    typedef enum logic { ALU_A_SEL_RS1, ALU_A_SEL_PC } alu_a_sel_t;
    typedef enum logic { ALU_B_SEL_RS2, ALU_B_SEL_IMM } alu_b_sel_t;

    typedef enum logic [2:0] {
        IG_DISABLED,
        IG_I_TYPE,
        IG_S_TYPE,
        IG_B_TYPE,
        IG_U_TYPE,
        IG_J_TYPE
    } ig_sel_t;

    typedef enum logic [1:0] { WB_SEL_ALU, WB_SEL_DMEM, WB_SEL_INC4, WB_SEL_CSR } wb_sel_t;
    typedef enum logic { PC_SEL_INC4, PC_SEL_ALU } pc_sel_t;

    // follows funct3[1:0]
    typedef enum logic [1:0] {
        CSR_OP_SEL_NONE,
        CSR_OP_SEL_ASSIGN,
        CSR_OP_SEL_SET,
        CSR_OP_SEL_CLEAR
    } csr_op_sel_t;

    typedef struct packed {
        logic        en;
        logic        we;
        logic        ui;
        csr_op_sel_t op_sel;
    } csr_ctrl_t;

    typedef struct packed {
        logic        load_inst;
        logic        store_inst;
        logic        branch_inst;
        logic        jump_inst;
        alu_op_t     alu_op_sel;
        alu_a_sel_t  alu_a_sel;
        alu_b_sel_t  alu_b_sel;
        ig_sel_t     ig_sel;
        logic        bc_uns;
        logic        dmem_en;
        logic        load_sm_en;
        wb_sel_t     wb_sel;
        logic        rd_we;
        csr_ctrl_t   csr_ctrl;
        logic [4:0]  rd_addr;
    } decoder_t;

    typedef struct packed {
        pc_sel_t pc_sel;
        logic    pc_we;
    } fe_ctrl_t;

    typedef struct packed {
        inst_t inst;
        addr_t pc;
    } fetch_item_t;

    typedef struct packed {
        decoder_t    decoded;
        fe_ctrl_t    fe_ctrl;
        logic [31:0] imm;
        addr_t       pc;
    } dec_item_t;

    typedef enum logic [1:0] { RST, STEADY, STALL_FLOW, STALL_IMEM } stall_state_t;

endpackage

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"
`default_nettype none

module decode_stage import decode_pkg::*; #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_DEPTH   = 2,
    parameter int OUT_CREDITS = 2
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    input  inst_t       in_inst,
    input  addr_t       in_pc,
    output logic        in_credit,
    output logic        out_valid,
    output decoder_t    out_decoded,
    output fe_ctrl_t    out_fe_ctrl,
    output logic [31:0] out_imm,
    output addr_t       out_pc,
    input  logic        out_credit_return
);

    fetch_item_t in_item;
    fetch_item_t in_head;
    dec_item_t   dec_item;
    dec_item_t   out_head;
    decoder_t    dec_decoded;
    fe_ctrl_t    dec_fe_ctrl;
    logic [31:0] dec_imm;
    logic        in_empty;
    logic        out_empty;
    logic        out_full;
    logic        dec_advance;
    logic        has_credit;

    assign in_item.inst = in_inst;
    assign in_item.pc   = in_pc;

    credit_fifo #(.DEPTH(IN_DEPTH), .T(fetch_item_t)) u_in_q (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (in_valid),
        .push_data (in_item),
        .pop       (dec_advance),
        .pop_data  (in_head),
        .empty     (in_empty),
        .full      ()
    );

    inst_decoder u_inst_decoder (
        .inst    (in_head.inst),
        .decoded (dec_decoded),
        .fe_ctrl (dec_fe_ctrl)
    );

    imm_gen u_imm_gen (
        .inst   (in_head.inst),
        .ig_sel (dec_decoded.ig_sel),
        .imm    (dec_imm)
    );

    decode_stall_fsm u_stall_fsm (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_empty    (in_empty),
        .out_full    (out_full),
        .dec_advance (dec_advance),
        .stall_state ()
    );

    assign dec_item.decoded = dec_decoded;
    assign dec_item.fe_ctrl = dec_fe_ctrl;
    assign dec_item.imm     = dec_imm;
    assign dec_item.pc      = in_head.pc;

    // advance only fires with a free slot here
    credit_fifo #(.DEPTH(OUT_DEPTH), .T(dec_item_t)) u_out_q (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (dec_advance),
        .push_data (dec_item),
        .pop       (out_valid),
        .pop_data  (out_head),
        .empty     (out_empty),
        .full      (out_full)
    );

    credit_counter #(.OUT_CREDITS(OUT_CREDITS)) u_credit_counter (
        .clk           (clk),
        .arst_n        (arst_n),
        .spend         (out_valid),
        .credit_return (out_credit_return),
        .has_credit    (has_credit)
    );

    assign in_credit = dec_advance; // one credit per pop
    assign out_valid = !out_empty && has_credit;

    // idle control fields between items
    assign out_decoded = out_valid ? out_head.decoded : `DECODER_RST_VAL;
    assign out_fe_ctrl = out_valid ? out_head.fe_ctrl : `FE_CTRL_RST_VAL;
    assign out_imm     = out_head.imm;
    assign out_pc      = out_head.pc;

endmodule

`default_nettype wire

// ==== hdl/decode_stall_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stall_fsm import decode_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         in_empty,
    input  logic         out_full,
    output logic         dec_advance,
    output stall_state_t stall_state
);

    stall_state_t next_state;

    always_comb begin
        case (stall_state)
            RST: next_state = STEADY;
            default: begin
                if (out_full) begin
                    next_state = STALL_FLOW; // downstream first
                end else if (in_empty) begin
                    next_state = STALL_IMEM;
                end else begin
                    next_state = STEADY;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stall_state <= RST;
        end else begin
            stall_state <= next_state;
        end
    end

    // state lags the queues by one cycle, so recheck them here
    assign dec_advance = (stall_state == STEADY) && !in_empty && !out_full;

endmodule

`default_nettype wire

// ==== hdl/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen import decode_pkg::*; (
    input  inst_t       inst,
    input  ig_sel_t     ig_sel,
    output logic [31:0] imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (ig_sel)
            IG_I_TYPE: imm = {{20{sign}}, inst[31:20]};
            IG_S_TYPE: imm = {{20{sign}}, inst[31:25], inst[11:7]};
            IG_B_TYPE: begin
                // bit 0 always zero
                imm = {{19{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            IG_U_TYPE: imm = {inst[31:12], 12'b0};
            IG_J_TYPE: begin
                imm = {{11{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default:   imm = '0; // disabled
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"
`default_nettype none

module inst_decoder import decode_pkg::*; (
    input  inst_t    inst,
    output decoder_t decoded,
    output fe_ctrl_t fe_ctrl
);

    opc7_t      opc7;
    logic [2:0] fn3;
    logic       fn7_b5;
    logic [4:0] rs1_addr;
    logic [4:0] rd_addr;
    logic       rd_nz;
    logic       rs1_zero;

    assign opc7     = opc7_t'(inst[6:0]);
    assign fn3      = inst[14:12];
    assign fn7_b5   = inst[30];
    assign rs1_addr = inst[19:15];
    assign rd_addr  = inst[11:7];
    assign rd_nz    = (rd_addr != `RF_X0_ZERO);
    assign rs1_zero = (rs1_addr == `RF_X0_ZERO);

    always_comb begin
        // fields not named below stay zero
        decoded          = `DECODER_RST_VAL;
        fe_ctrl          = `FE_CTRL_RST_VAL;
        decoded.csr_ctrl = `CSR_CTRL_RST_VAL;

        case (opc7)
            OPC7_R_TYPE: begin
                decoded.alu_op_sel = alu_op_t'({fn7_b5, fn3});
                decoded.alu_a_sel  = ALU_A_SEL_RS1;
                decoded.alu_b_sel  = ALU_B_SEL_RS2;
                decoded.wb_sel     = WB_SEL_ALU;
            end
            OPC7_I_TYPE: begin
                decoded.alu_op_sel = (fn3[1:0] == 2'b01) ?
                    alu_op_t'({fn7_b5, fn3}) : // shift, srl vs sra
                    alu_op_t'({1'b0, fn3});
                decoded.alu_b_sel  = ALU_B_SEL_IMM;
                decoded.ig_sel     = IG_I_TYPE;
                decoded.wb_sel     = WB_SEL_ALU;
            end
            OPC7_LOAD: begin
                decoded.load_inst  = 1'b1;
                decoded.alu_op_sel = ALU_OP_ADD;
                decoded.alu_b_sel  = ALU_B_SEL_IMM;
                decoded.ig_sel     = IG_I_TYPE;
                decoded.dmem_en    = 1'b1;
                decoded.load_sm_en = 1'b1;
                decoded.wb_sel     = WB_SEL_DMEM;
            end
            OPC7_STORE: begin
                decoded.store_inst = 1'b1;
                decoded.alu_op_sel = ALU_OP_ADD;
                decoded.alu_b_sel  = ALU_B_SEL_IMM;
                decoded.ig_sel     = IG_S_TYPE;
                decoded.dmem_en    = 1'b1;
            end
            OPC7_BRANCH: begin
                decoded.branch_inst = 1'b1;
                decoded.alu_op_sel  = ALU_OP_ADD; // target = pc + imm
                decoded.alu_a_sel   = ALU_A_SEL_PC;
                decoded.alu_b_sel   = ALU_B_SEL_IMM;
                decoded.ig_sel      = IG_B_TYPE;
                decoded.bc_uns      = fn3[1]; // bltu, bgeu
            end
            OPC7_JALR: begin
                fe_ctrl.pc_sel     = PC_SEL_ALU;
                decoded.jump_inst  = 1'b1;
                decoded.alu_op_sel = ALU_OP_ADD;
                decoded.alu_b_sel  = ALU_B_SEL_IMM;
                decoded.ig_sel     = IG_I_TYPE;
                decoded.wb_sel     = WB_SEL_INC4;
            end
            OPC7_JAL: begin
                fe_ctrl.pc_sel     = PC_SEL_ALU;
                decoded.jump_inst  = 1'b1;
                decoded.alu_op_sel = ALU_OP_ADD;
                decoded.alu_a_sel  = ALU_A_SEL_PC;
                decoded.alu_b_sel  = ALU_B_SEL_IMM;
                decoded.ig_sel     = IG_J_TYPE;
                decoded.wb_sel     = WB_SEL_INC4;
            end
            OPC7_LUI: begin
                decoded.alu_op_sel = ALU_OP_PASS_B;
                decoded.alu_b_sel  = ALU_B_SEL_IMM;
                decoded.ig_sel     = IG_U_TYPE;
                decoded.wb_sel     = WB_SEL_ALU;
            end
            OPC7_AUIPC: begin
                decoded.alu_op_sel = ALU_OP_ADD;
                decoded.alu_a_sel  = ALU_A_SEL_PC;
                decoded.alu_b_sel  = ALU_B_SEL_IMM;
                decoded.ig_sel     = IG_U_TYPE;
                decoded.wb_sel     = WB_SEL_ALU;
            end
            OPC7_SYSTEM: begin
                // csrrw with rs1 = x0 still writes but skips the read side
                decoded.csr_ctrl.en =
                    !((fn3[1:0] == CSR_OP_SEL_ASSIGN) && rs1_zero);
                decoded.csr_ctrl.we =
                    !(((fn3[1:0] == CSR_OP_SEL_SET) || (fn3[1:0] == CSR_OP_SEL_CLEAR))
                      && rs1_zero);
                decoded.csr_ctrl.ui     = fn3[2]; // zimm in rs1 field
                decoded.csr_ctrl.op_sel = csr_op_sel_t'(fn3[1:0]);
                decoded.alu_a_sel       = ALU_A_SEL_RS1;
                decoded.wb_sel          = WB_SEL_CSR;
            end
            default: ;
        endcase

        if (opc7 inside {OPC7_R_TYPE, OPC7_I_TYPE, OPC7_LOAD, OPC7_JALR, OPC7_JAL,
                         OPC7_LUI, OPC7_AUIPC, OPC7_SYSTEM}) begin
            decoded.rd_we   = rd_nz;
            decoded.rd_addr = rd_addr; // only for classes with a destination
        end
        if (opc7 inside {OPC7_R_TYPE, OPC7_I_TYPE, OPC7_LOAD, OPC7_STORE, OPC7_BRANCH,
                         OPC7_JALR, OPC7_JAL, OPC7_LUI, OPC7_AUIPC, OPC7_SYSTEM}) begin
            fe_ctrl.pc_we = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== include/decode_defines.svh ====
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

`default_nettype none

// idle values, all fields zero
// expand inside a scope that imports decode_pkg

`define DECODER_RST_VAL decoder_t'('0)

`define FE_CTRL_RST_VAL fe_ctrl_t'('0)

`define CSR_CTRL_RST_VAL csr_ctrl_t'('0)

// x0 never gets written
`define RF_X0_ZERO 5'd0

`default_nettype wire

`endif

// ==== verification/decode_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_assert #(
    parameter int OUT_CREDITS = 2
) (
    input logic clk,
    input logic arst_n,
    input logic out_valid,
    input logic out_credit_return,
    input logic in_valid,
    input logic in_credit
);

    int unsigned accepted;
    int unsigned released;
    int          credits; // downstream window as seen at the ports

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            accepted <= 0;
            released <= 0;
            credits  <= OUT_CREDITS;
        end else begin
            if (in_valid) accepted <= accepted + 1;
            if (in_credit) released <= released + 1;
            credits <= credits - int'(out_valid) + int'(out_credit_return);
        end
    end

    a_valid_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> (credits > 0))
        else $error("out_valid high with no downstream credit");

    a_quiet_in_reset: assert property (@(posedge clk)
        (!arst_n || $rose(arst_n)) |-> !out_valid)
        else $error("out_valid high during or just after reset");

    // a pop always follows an earlier push
    a_credit_bounded: assert property (@(posedge clk) disable iff (!arst_n)
        in_credit |-> (released < accepted))
        else $error("in_credit pulse without an accepted item");

endmodule

bind decode_stage decode_assert #(.OUT_CREDITS(OUT_CREDITS)) u_assert (
    .clk               (clk),
    .arst_n            (arst_n),
    .out_valid         (out_valid),
    .out_credit_return (out_credit_return),
    .in_valid          (in_valid),
    .in_credit         (in_credit)
);

`default_nettype wire

// ==== verification/decode_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_checker import decode_pkg::*; #(
    parameter int N_ROWS      = 1,
    parameter int OUT_CREDITS = 2
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    input  logic        in_credit,
    input  logic        out_valid,
    input  decoder_t    out_decoded,
    input  fe_ctrl_t    out_fe_ctrl,
    input  logic [31:0] out_imm,
    input  addr_t       out_pc,
    input  logic        out_credit_return,
    input  dec_item_t   exp_items [N_ROWS],
    input  logic        end_check,
    output int          mismatch_errs,
    output int          protocol_errs
);

    int idx          = 0;
    int accepted     = 0;
    int credit_seen  = 0;
    int down_credits = OUT_CREDITS;
    bit end_done     = 1'b0;

    initial begin
        mismatch_errs = 0;
        protocol_errs = 0;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        $display("Mismatch at %0t: %s expected %h got %h (row %0d)",
                 $time, name, exp_val, got_val, idx);
        mismatch_errs = mismatch_errs + 1;
    endtask

    task automatic compare_item();
        dec_item_t e;
        e = exp_items[idx];
        if (out_decoded !== e.decoded) report_mismatch("out_decoded", 32'(e.decoded),
                                                       32'(out_decoded));
        if (out_fe_ctrl !== e.fe_ctrl) report_mismatch("out_fe_ctrl", 32'(e.fe_ctrl),
                                                       32'(out_fe_ctrl));
        if (out_imm !== e.imm) report_mismatch("out_imm", e.imm, out_imm);
        if (out_pc !== e.pc) report_mismatch("out_pc", e.pc, out_pc);
    endtask

    always @(posedge clk) begin
        if (arst_n) begin
            if (in_valid) accepted = accepted + 1;
            if (in_credit) begin
                credit_seen = credit_seen + 1;
                if (credit_seen > accepted) begin
                    $display("Error at %0t: in_credit pulsed with no accepted item left", $time);
                    protocol_errs = protocol_errs + 1;
                end
            end
            if (out_valid) begin
                if (down_credits == 0) begin
                    $display("Error at %0t: credit overrun, item sent with no credit", $time);
                    protocol_errs = protocol_errs + 1;
                end
                down_credits = down_credits - 1;
                if (idx >= N_ROWS) begin
                    $display("Error at %0t: extra output beyond the %0d expected", $time, N_ROWS);
                    protocol_errs = protocol_errs + 1;
                end else begin
                    compare_item();
                    idx = idx + 1;
                end
            end
            if (out_credit_return) down_credits = down_credits + 1;

            if (end_check && !end_done) begin
                end_done = 1'b1;
                if (idx < N_ROWS) begin
                    $display("Error: only %0d of %0d outputs arrived", idx, N_ROWS);
                    protocol_errs = protocol_errs + 1;
                end
                if (credit_seen != accepted) begin
                    $display("Error: %0d in_credit pulses for %0d accepted items",
                             credit_seen, accepted);
                    protocol_errs = protocol_errs + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage import decode_pkg::*; ;

    localparam int IN_DEPTH        = 4;
    localparam int OUT_DEPTH       = 2;
    localparam int OUT_CREDITS     = 2;
    localparam int CLK_PERIOD      = 8;
    localparam int N_ROWS          = 28;
    localparam int WATCHDOG_CYCLES = N_ROWS * 20 + 200;
    localparam int SEED            = 39315;

    localparam decoder_t DEC_IDLE = '0;
    localparam fe_ctrl_t FE_IDLE  = '0;
    localparam fe_ctrl_t FE_SEQ   = '{PC_SEL_INC4, 1'b1};
    localparam fe_ctrl_t FE_JMP   = '{PC_SEL_ALU, 1'b1};

    logic        clk = 1'b0;
    logic        arst_n;
    logic        in_valid;
    inst_t       in_inst;
    addr_t       in_pc;
    logic        in_credit;
    logic        out_valid;
    decoder_t    out_decoded;
    fe_ctrl_t    out_fe_ctrl;
    logic [31:0] out_imm;
    addr_t       out_pc;
    logic        out_credit_return;
    logic        end_check;
    int          mismatch_errs;
    int          protocol_errs;

    inst_t     inst_tab [N_ROWS];
    dec_item_t exp_tab  [N_ROWS];

    int accepted     = 0;
    int credit_seen  = 0; // in_credit pulses back from the DUT
    int sent_cnt     = 0;
    int returned_cnt = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    decode_stage #(
        .IN_DEPTH    (IN_DEPTH),
        .OUT_DEPTH   (OUT_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_dut (
        .clk               (clk),
        .arst_n            (arst_n),
        .in_valid          (in_valid),
        .in_inst           (in_inst),
        .in_pc             (in_pc),
        .in_credit         (in_credit),
        .out_valid         (out_valid),
        .out_decoded       (out_decoded),
        .out_fe_ctrl       (out_fe_ctrl),
        .out_imm           (out_imm),
        .out_pc            (out_pc),
        .out_credit_return (out_credit_return)
    );

    decode_checker #(.N_ROWS(N_ROWS), .OUT_CREDITS(OUT_CREDITS)) u_chk (
        .clk               (clk),
        .arst_n            (arst_n),
        .in_valid          (in_valid),
        .in_credit         (in_credit),
        .out_valid         (out_valid),
        .out_decoded       (out_decoded),
        .out_fe_ctrl       (out_fe_ctrl),
        .out_imm           (out_imm),
        .out_pc            (out_pc),
        .out_credit_return (out_credit_return),
        .exp_items         (exp_tab),
        .end_check         (end_check),
        .mismatch_errs     (mismatch_errs),
        .protocol_errs     (protocol_errs)
    );

    // kinds = {load, store, branch, jump}, mem = {bc_uns, dmem_en, load_sm_en}
    function automatic decoder_t ctl_fields(
        input logic [3:0] kinds,
        input alu_op_t    op,
        input alu_a_sel_t a_sel,
        input alu_b_sel_t b_sel,
        input ig_sel_t    ig,
        input logic [2:0] mem,
        input wb_sel_t    wb,
        input logic       rd_we,
        input logic [4:0] rd
    );
        decoder_t d;
        d             = '0;
        d.load_inst   = kinds[3];
        d.store_inst  = kinds[2];
        d.branch_inst = kinds[1];
        d.jump_inst   = kinds[0];
        d.alu_op_sel  = op;
        d.alu_a_sel   = a_sel;
        d.alu_b_sel   = b_sel;
        d.ig_sel      = ig;
        d.bc_uns      = mem[2];
        d.dmem_en     = mem[1];
        d.load_sm_en  = mem[0];
        d.wb_sel      = wb;
        d.rd_we       = rd_we;
        d.rd_addr     = rd;
        return d;
    endfunction

    // system class: rs1 into alu port a, writeback from the csr
    function automatic decoder_t csr_fields(
        input logic        rd_we,
        input logic [4:0]  rd,
        input logic        en,
        input logic        we,
        input logic        ui,
        input csr_op_sel_t op
    );
        decoder_t d;
        d = ctl_fields(4'b0000, ALU_OP_ADD, ALU_A_SEL_RS1, ALU_B_SEL_RS2, IG_DISABLED,
            3'b000, WB_SEL_CSR, rd_we, rd);
        d.csr_ctrl.en     = en;
        d.csr_ctrl.we     = we;
        d.csr_ctrl.ui     = ui;
        d.csr_ctrl.op_sel = op;
        return d;
    endfunction

    task automatic set_row(input int i, input inst_t w, input decoder_t d,
                           input fe_ctrl_t f, input logic [31:0] imm);
        inst_tab[i]        = w;
        exp_tab[i].decoded = d;
        exp_tab[i].fe_ctrl = f;
        exp_tab[i].imm     = imm;
        exp_tab[i].pc      = 32'h0000_1000 + 32'(4 * i);
    endtask

    task automatic fill_table();
        // r type, funct7 bit 5 picks sub and sra
        set_row(0, 32'h003100B3, ctl_fields(4'b0000, ALU_OP_ADD, ALU_A_SEL_RS1, ALU_B_SEL_RS2,
            IG_DISABLED, 3'b000, WB_SEL_ALU, 1'b1, 5'd1), FE_SEQ, 32'h0);
        set_row(1, 32'h407302B3, ctl_fields(4'b0000, ALU_OP_SUB, ALU_A_SEL_RS1, ALU_B_SEL_RS2,
            IG_DISABLED, 3'b000, WB_SEL_ALU, 1'b1, 5'd5), FE_SEQ, 32'h0);
        set_row(2, 32'h40A4D433, ctl_fields(4'b0000, ALU_OP_SRA, ALU_A_SEL_RS1, ALU_B_SEL_RS2,
            IG_DISABLED, 3'b000, WB_SEL_ALU, 1'b1, 5'd8), FE_SEQ, 32'h0);
        set_row(3, 32'h00208033, ctl_fields(4'b0000, ALU_OP_ADD, ALU_A_SEL_RS1, ALU_B_SEL_RS2,
            IG_DISABLED, 3'b000, WB_SEL_ALU, 1'b0, 5'd0), FE_SEQ, 32'h0);
        // immediate ops: srai keeps bit 30, xori with imm 0x400 drops it
        set_row(4, 32'hFFF10093, ctl_fields(4'b0000, ALU_OP_ADD, ALU_A_SEL_RS1, ALU_B_SEL_IMM,
            IG_I_TYPE, 3'b000, WB_SEL_ALU, 1'b1, 5'd1), FE_SEQ, 32'hFFFF_FFFF);
        set_row(5, 32'h40525193, ctl_fields(4'b0000, ALU_OP_SRA, ALU_A_SEL_RS1, ALU_B_SEL_IMM,
            IG_I_TYPE, 3'b000, WB_SEL_ALU, 1'b1, 5'd3), FE_SEQ, 32'h0000_0405);
        set_row(6, 32'h4003C313, ctl_fields(4'b0000, ALU_OP_XOR, ALU_A_SEL_RS1, ALU_B_SEL_IMM,
            IG_I_TYPE, 3'b000, WB_SEL_ALU, 1'b1, 5'd6), FE_SEQ, 32'h0000_0400);
        set_row(7, 32'hFFC12503, ctl_fields(4'b1000, ALU_OP_ADD, ALU_A_SEL_RS1, ALU_B_SEL_IMM,
            IG_I_TYPE, 3'b011, WB_SEL_DMEM, 1'b1, 5'd10), FE_SEQ, 32'hFFFF_FFFC);
        set_row(8, 32'h0080A003, ctl_fields(4'b1000, ALU_OP_ADD, ALU_A_SEL_RS1, ALU_B_SEL_IMM,
            IG_I_TYPE, 3'b011, WB_SEL_DMEM, 1'b0, 5'd0), FE_SEQ, 32'h0000_0008);
        set_row(9, 32'hFE51AC23, ctl_fields(4'b0100, ALU_OP_ADD, ALU_A_SEL_RS1, ALU_B_SEL_IMM,
            IG_S_TYPE, 3'b010, WB_SEL_ALU, 1'b0, 5'd0), FE_SEQ, 32'hFFFF_FFF8);
        set_row(10, 32'hFE2088E3, ctl_fields(4'b0010, ALU_OP_ADD, ALU_A_SEL_PC, ALU_B_SEL_IMM,
            IG_B_TYPE, 3'b000, WB_SEL_ALU, 1'b0, 5'd0), FE_SEQ, 32'hFFFF_FFF0);
        set_row(11, 32'h0041E463, ctl_fields(4'b0010, ALU_OP_ADD, ALU_A_SEL_PC, ALU_B_SEL_IMM,
            IG_B_TYPE, 3'b100, WB_SEL_ALU, 1'b0, 5'd0), FE_SEQ, 32'h0000_0008);
        set_row(12, 32'h00C280E7, ctl_fields(4'b0001, ALU_OP_ADD, ALU_A_SEL_RS1, ALU_B_SEL_IMM,
            IG_I_TYPE, 3'b000, WB_SEL_INC4, 1'b1, 5'd1), FE_JMP, 32'h0000_000C);
        set_row(13, 32'h001000EF, ctl_fields(4'b0001, ALU_OP_ADD, ALU_A_SEL_PC, ALU_B_SEL_IMM,
            IG_J_TYPE, 3'b000, WB_SEL_INC4, 1'b1, 5'd1), FE_JMP, 32'h0000_0800);
        set_row(14, 32'hFFDFF06F, ctl_fields(4'b0001, ALU_OP_ADD, ALU_A_SEL_PC, ALU_B_SEL_IMM,
            IG_J_TYPE, 3'b000, WB_SEL_INC4, 1'b0, 5'd0), FE_JMP, 32'hFFFF_FFFC);
        set_row(15, 32'hABCDE3B7, ctl_fields(4'b0000, ALU_OP_PASS_B, ALU_A_SEL_RS1, ALU_B_SEL_IMM,
            IG_U_TYPE, 3'b000, WB_SEL_ALU, 1'b1, 5'd7), FE_SEQ, 32'hABCD_E000);
        set_row(16, 32'h12345117, ctl_fields(4'b0000, ALU_OP_ADD, ALU_A_SEL_PC, ALU_B_SEL_IMM,
            IG_U_TYPE, 3'b000, WB_SEL_ALU, 1'b1, 5'd2), FE_SEQ, 32'h1234_5000);
        // csr ops with rs1 zero and non zero
        set_row(17, 32'h30001073, csr_fields(1'b0, 5'd0, 1'b0, 1'b1, 1'b0, CSR_OP_SEL_ASSIGN),
            FE_SEQ, 32'h0);
        set_row(18, 32'h300211F3, csr_fields(1'b1, 5'd3, 1'b1, 1'b1, 1'b0, CSR_OP_SEL_ASSIGN),
            FE_SEQ, 32'h0);
        set_row(19, 32'h341022F3, csr_fields(1'b1, 5'd5, 1'b1, 1'b0, 1'b0, CSR_OP_SEL_SET),
            FE_SEQ, 32'h0);
        set_row(20, 32'h3411E373, csr_fields(1'b1, 5'd6, 1'b1, 1'b1, 1'b1, CSR_OP_SEL_SET),
            FE_SEQ, 32'h0);
        set_row(21, 32'h3004B473, csr_fields(1'b1, 5'd8, 1'b1, 1'b1, 1'b0, CSR_OP_SEL_CLEAR),
            FE_SEQ, 32'h0);
        set_row(22, 32'h300074F3, csr_fields(1'b1, 5'd9, 1'b1, 1'b0, 1'b1, CSR_OP_SEL_CLEAR),
            FE_SEQ, 32'h0);
        set_row(23, 32'hFFFFFFFF, DEC_IDLE, FE_IDLE, 32'h0); // opcode 7f, not rv32i
        // rd x0 on slli, jalr, lui and auipc
        set_row(24, 32'h00311013, ctl_fields(4'b0000, ALU_OP_SLL, ALU_A_SEL_RS1, ALU_B_SEL_IMM,
            IG_I_TYPE, 3'b000, WB_SEL_ALU, 1'b0, 5'd0), FE_SEQ, 32'h0000_0003);
        set_row(25, 32'h00008067, ctl_fields(4'b0001, ALU_OP_ADD, ALU_A_SEL_RS1, ALU_B_SEL_IMM,
            IG_I_TYPE, 3'b000, WB_SEL_INC4, 1'b0, 5'd0), FE_JMP, 32'h0);
        set_row(26, 32'h80000037, ctl_fields(4'b0000, ALU_OP_PASS_B, ALU_A_SEL_RS1, ALU_B_SEL_IMM,
            IG_U_TYPE, 3'b000, WB_SEL_ALU, 1'b0, 5'd0), FE_SEQ, 32'h8000_0000);
        set_row(27, 32'hFFFFF017, ctl_fields(4'b0000, ALU_OP_ADD, ALU_A_SEL_PC, ALU_B_SEL_IMM,
            IG_U_TYPE, 3'b000, WB_SEL_ALU, 1'b0, 5'd0), FE_SEQ, 32'hFFFF_F000);
    endtask

    always @(posedge clk) begin
        if (in_credit) credit_seen <= credit_seen + 1;
        if (out_valid) sent_cnt <= sent_cnt + 1;
    end

    // downstream credit return, 0 to 5 cycles apart
    initial begin
        int gap_left;
        gap_left          = 0;
        out_credit_return = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_credit_return = 1'b0;
            if (returned_cnt < sent_cnt) begin
                if (gap_left == 0) begin
                    out_credit_return = 1'b1;
                    returned_cnt      = returned_cnt + 1;
                    gap_left          = $urandom_range(5, 0);
                end else begin
                    gap_left = gap_left - 1;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: outputs incomplete after %0d cycles (%0d of %0d sent)",
                 WATCHDOG_CYCLES, sent_cnt, N_ROWS);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int row;
        void'($urandom(SEED));
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_inst   = '0;
        in_pc     = '0;
        end_check = 1'b0;
        row       = 0;
        fill_table();
        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;

        while (row < N_ROWS) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            // send only while an upstream credit is held, with random idle cycles
            if ((accepted - credit_seen) < IN_DEPTH && $urandom_range(3, 0) != 0) begin
                in_valid = 1'b1;
                in_inst  = inst_tab[row];
                in_pc    = exp_tab[row].pc;
                accepted = accepted + 1;
                row      = row + 1;
            end
        end
        @(posedge clk);
        #1 in_valid = 1'b0;

        wait (sent_cnt == N_ROWS);
        repeat (10) @(posedge clk); // room for stray outputs
        #1 end_check = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        $display("error counts: mismatch %0d, protocol %0d", mismatch_errs, protocol_errs);
        if (mismatch_errs == 0 && protocol_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
